//--- logic/prbs_pkg.sv
package prbs_pkg;

	// --------------------------------------------------
	// Widths and counts
	// --------------------------------------------------
	localparam int WORD_WIDTH      = 8;  // One serializer word.
	localparam int ERR_COUNT_WIDTH = 16;
	localparam int LOCK_WORDS      = 4;  // Clean words needed for lock.
	localparam int LFSR_WIDTH      = 31; // Largest order.
	localparam int HEARTBEAT_BIT   = 7;  // Toggles every 128 words.

	localparam int LOCK_CNT_WIDTH = $clog2(LOCK_WORDS + 1);
	localparam int SEED_CNT_WIDTH = 3;
	localparam int BIT_ERR_WIDTH  = $clog2(WORD_WIDTH + 1);

	// Polynomials x^order + x^tap + 1.
	localparam int PRBS7_ORDER  = 7;
	localparam int PRBS7_TAP    = 6;
	localparam int PRBS15_ORDER = 15;
	localparam int PRBS15_TAP   = 14;
	localparam int PRBS31_ORDER = 31;
	localparam int PRBS31_TAP   = 28;

	typedef enum logic [1:0] {
		MODE_OFF    = 2'd0,
		MODE_PRBS7  = 2'd1,
		MODE_PRBS15 = 2'd2,
		MODE_PRBS31 = 2'd3
	} prbs_mode_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_CLEAR,
		ST_RUN_ACK,
		ST_RUN
	} ctrl_state_t;

	typedef enum logic [1:0] {
		CK_IDLE,
		CK_SEED,
		CK_COMPARE
	} check_state_t;

	// --------------------------------------------------
	// Sequence helpers
	// --------------------------------------------------
	function automatic int prbs_order(prbs_mode_t mode);
		case (mode)
			MODE_PRBS7:  return PRBS7_ORDER;
			MODE_PRBS15: return PRBS15_ORDER;
			MODE_PRBS31: return PRBS31_ORDER;
			default:     return 0;
		endcase
	endfunction

	function automatic int prbs_seed_words(prbs_mode_t mode);
		return (prbs_order(mode) + WORD_WIDTH - 1) / WORD_WIDTH;
	endfunction

	// Eight Fibonacci steps, the earliest bit lands in bit 7.
	function automatic logic [WORD_WIDTH-1:0] prbs_next_word(
		logic [LFSR_WIDTH-1:0] state,
		prbs_mode_t mode
	);
		logic [LFSR_WIDTH-1:0] s;
		logic [WORD_WIDTH-1:0] w;
		logic fb;
		s = state;
		w = '0;
		for (int i = WORD_WIDTH - 1; i >= 0; i--) begin
			case (mode)
				MODE_PRBS7:  fb = s[PRBS7_ORDER-1] ^ s[PRBS7_TAP-1];
				MODE_PRBS15: fb = s[PRBS15_ORDER-1] ^ s[PRBS15_TAP-1];
				MODE_PRBS31: fb = s[PRBS31_ORDER-1] ^ s[PRBS31_TAP-1];
				default:     fb = 1'b0;
			endcase
			w[i] = fb;
			s = {s[LFSR_WIDTH-2:0], fb};
		end
		return w;
	endfunction

	// Register contents after a word of sequence bits was shifted in.
	function automatic logic [LFSR_WIDTH-1:0] prbs_shift_in(
		logic [LFSR_WIDTH-1:0] state,
		logic [WORD_WIDTH-1:0] word
	);
		return {state[LFSR_WIDTH-WORD_WIDTH-1:0], word};
	endfunction

endpackage

//--- logic/prbs_ctrl_if.sv
`timescale 1ns/1ps

interface prbs_ctrl_if;
	import prbs_pkg::*;

	prbs_mode_t                 mode;
	logic                       run;
	logic                       clear;   // One cycle, restarts both ends.
	logic                       tx_fire; // A word left the generator.
	logic                       locked;
	logic [ERR_COUNT_WIDTH-1:0] error_count;

	modport ctrl (
		output mode, run, clear,
		input  tx_fire, locked, error_count
	);

	modport gen (
		input  mode, run, clear,
		output tx_fire
	);

	modport check (
		input  mode, run, clear,
		output locked, error_count
	);

endinterface

//--- logic/prbs_word_gen.sv
`timescale 1ns/1ps

module prbs_word_gen (
	input  logic                            word_clock,
	input  logic                            rst_n,
	prbs_ctrl_if.gen                        ctl,
	output logic [prbs_pkg::WORD_WIDTH-1:0] tx_word,
	output logic                            tx_valid
);
	import prbs_pkg::*;

	logic [LFSR_WIDTH-1:0] lfsr;
	logic [WORD_WIDTH-1:0] next_word;

	always_comb begin
		next_word = prbs_next_word(lfsr, ctl.mode);
	end

	// --------------------------------------------------
	// Shift register and valid
	// --------------------------------------------------
	always_ff @(posedge word_clock) begin
		if (!rst_n) begin
			lfsr     <= '1;
			tx_valid <= 1'b0;
		end else begin
			tx_valid <= ctl.run;
			if (ctl.clear) begin
				lfsr <= '1; // Every pattern starts from all ones.
			end else if (ctl.run) begin
				lfsr <= prbs_shift_in(lfsr, next_word);
			end
		end
	end

	always_ff @(posedge word_clock) begin
		if (ctl.run) begin
			tx_word <= next_word;
		end
	end

	assign ctl.tx_fire = tx_valid; // Heartbeat event.

endmodule

//--- logic/prbs_word_check.sv
`timescale 1ns/1ps

module prbs_word_check (
	input  logic                            word_clock,
	input  logic                            rst_n,
	prbs_ctrl_if.check                      ctl,
	input  logic [prbs_pkg::WORD_WIDTH-1:0] rx_word,
	input  logic                            rx_valid
);
	import prbs_pkg::*;

	check_state_t               state;
	logic [LFSR_WIDTH-1:0]      lfsr;
	logic [SEED_CNT_WIDTH-1:0]  seed_cnt;
	logic [LOCK_CNT_WIDTH-1:0]  clean_cnt;
	logic                       locked;
	logic [ERR_COUNT_WIDTH-1:0] err_count;

	logic [WORD_WIDTH-1:0]      pred_word;
	logic [WORD_WIDTH-1:0]      diff;
	logic [BIT_ERR_WIDTH-1:0]   bit_errs;
	logic [ERR_COUNT_WIDTH:0]   err_sum;
	logic [ERR_COUNT_WIDTH-1:0] err_next;
	logic                       take;
	logic                       seed_last;

	assign take      = rx_valid && ctl.run;
	assign seed_last = int'(seed_cnt) == prbs_seed_words(ctl.mode) - 1;

	// --------------------------------------------------
	// Prediction and error count
	// --------------------------------------------------
	always_comb begin
		pred_word = prbs_next_word(lfsr, ctl.mode);
		diff      = pred_word ^ rx_word;
		bit_errs  = '0;
		for (int i = 0; i < WORD_WIDTH; i++) begin
			bit_errs = bit_errs + BIT_ERR_WIDTH'(diff[i]);
		end
		err_sum  = {1'b0, err_count} + (ERR_COUNT_WIDTH + 1)'(bit_errs);
		err_next = err_sum[ERR_COUNT_WIDTH] ? '1 : err_sum[ERR_COUNT_WIDTH-1:0]; // Saturate.
	end

	always_ff @(posedge word_clock) begin
		if (!rst_n) begin
			state     <= CK_IDLE;
			seed_cnt  <= '0;
			clean_cnt <= '0;
			locked    <= 1'b0;
			err_count <= '0;
		end else if (ctl.clear) begin
			state     <= CK_IDLE;
			seed_cnt  <= '0;
			clean_cnt <= '0;
			locked    <= 1'b0;
			err_count <= '0;
		end else begin
			unique case (state)
				// Wait for a gap so a word still in flight from the old
				// pattern is never taken as seed.
				CK_IDLE: begin
					if (!rx_valid) begin
						state <= CK_SEED;
					end
				end
				CK_SEED: begin
					if (take) begin
						if (seed_last) begin
							seed_cnt <= '0;
							state    <= CK_COMPARE;
						end else begin
							seed_cnt <= seed_cnt + 1'b1;
						end
					end
				end
				CK_COMPARE: begin
					if (take) begin
						err_count <= err_next;
						if (bit_errs != '0) begin
							locked    <= 1'b0;
							clean_cnt <= '0;
						end else if (clean_cnt == LOCK_CNT_WIDTH'(LOCK_WORDS - 1)) begin
							locked <= 1'b1;
						end else begin
							clean_cnt <= clean_cnt + 1'b1;
						end
					end
				end
				default: state <= CK_IDLE;
			endcase
		end
	end

	// Seed from the line, then free-run on the prediction.
	always_ff @(posedge word_clock) begin
		if (take && state == CK_SEED) begin
			lfsr <= prbs_shift_in(lfsr, rx_word);
		end else if (take && state == CK_COMPARE) begin
			lfsr <= prbs_shift_in(lfsr, pred_word);
		end
	end

	assign ctl.locked      = locked;
	assign ctl.error_count = err_count;

endmodule

//--- logic/link_test_ctrl.sv
`timescale 1ns/1ps

module link_test_ctrl (
	input  logic                                 word_clock,
	input  logic                                 rst_n,
	input  logic                                 cmd_req,
	input  prbs_pkg::prbs_mode_t                 cmd_mode,
	output logic                                 cmd_ack,
	prbs_ctrl_if.ctrl                            ctl,
	output logic [prbs_pkg::ERR_COUNT_WIDTH-1:0] error_count,
	output logic [3:0]                           leds
);
	import prbs_pkg::*;

	ctrl_state_t            state;
	prbs_mode_t             mode;
	logic [HEARTBEAT_BIT:0] word_count;
	logic                   run;

	// --------------------------------------------------
	// Four-phase command handshake
	// --------------------------------------------------
	always_ff @(posedge word_clock) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			mode  <= MODE_OFF;
		end else begin
			unique case (state)
				ST_IDLE, ST_RUN: begin
					if (cmd_req) begin
						mode  <= cmd_mode; // Host holds it stable with req.
						state <= ST_CLEAR;
					end
				end
				ST_CLEAR: state <= ST_RUN_ACK;
				ST_RUN_ACK: begin
					if (!cmd_req) begin
						state <= ST_RUN;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign run     = (state == ST_RUN_ACK || state == ST_RUN) && mode != MODE_OFF;
	assign cmd_ack = state == ST_RUN_ACK;

	assign ctl.mode  = mode;
	assign ctl.run   = run;
	assign ctl.clear = state == ST_CLEAR;

	// Transmitted word counter for the heartbeat.
	always_ff @(posedge word_clock) begin
		if (!rst_n) begin
			word_count <= '0;
		end else if (state == ST_CLEAR) begin
			word_count <= '0;
		end else if (ctl.tx_fire) begin
			word_count <= word_count + 1'b1;
		end
	end

	// --------------------------------------------------
	// Status
	// --------------------------------------------------
	assign error_count = ctl.error_count;

	assign leds[3] = ctl.locked;
	assign leds[2] = ctl.error_count != '0;
	assign leds[1] = run;
	assign leds[0] = word_count[HEARTBEAT_BIT];

endmodule

//--- logic/prbs_link_test.sv
`timescale 1ns/1ps

module prbs_link_test (
	input  logic                                 word_clock,
	input  logic                                 rst_n,
	input  logic                                 cmd_req,
	input  prbs_pkg::prbs_mode_t                 cmd_mode,
	output logic                                 cmd_ack,
	output logic [prbs_pkg::WORD_WIDTH-1:0]      tx_word,
	output logic                                 tx_valid,
	input  logic [prbs_pkg::WORD_WIDTH-1:0]      rx_word,
	input  logic                                 rx_valid,
	output logic [prbs_pkg::ERR_COUNT_WIDTH-1:0] error_count,
	output logic [3:0]                           leds
);

	prbs_ctrl_if ctl_if ();

	link_test_ctrl u_ctrl (
		.word_clock  (word_clock),
		.rst_n       (rst_n),
		.cmd_req     (cmd_req),
		.cmd_mode    (cmd_mode),
		.cmd_ack     (cmd_ack),
		.ctl         (ctl_if.ctrl),
		.error_count (error_count),
		.leds        (leds)
	);

	// Transmit side, toward the serializer.
	prbs_word_gen u_gen (
		.word_clock (word_clock),
		.rst_n      (rst_n),
		.ctl        (ctl_if.gen),
		.tx_word    (tx_word),
		.tx_valid   (tx_valid)
	);

	// Receive side, from the deserializer.
	prbs_word_check u_check (
		.word_clock (word_clock),
		.rst_n      (rst_n),
		.ctl        (ctl_if.check),
		.rx_word    (rx_word),
		.rx_valid   (rx_valid)
	);

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic word_clock,
	output logic rst_n
);

	initial begin
		word_clock = 1'b0;
		forever #5 word_clock = ~word_clock; // 10 ns period.
	end

	// Reset is held low over three rising edges.
	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge word_clock);
		rst_n <= 1'b1;
	end

endmodule

//--- test/tb_prbs_link_test.sv
`timescale 1ns/1ps

module tb_prbs_link_test;
	import prbs_pkg::*;

	localparam int PATTERN_WORDS    = 64;
	localparam int CLEAN_WORDS      = 32;
	localparam int ERROR_WORDS      = 6;
	localparam int HEARTBEAT_WORDS  = 300;
	localparam int HANDSHAKE_CYCLES = 6;
	// Ten commands, the word counts of all tests and a margin.
	localparam int TIMEOUT_CYCLES = 10 * HANDSHAKE_CYCLES + 3 * PATTERN_WORDS
		+ 3 * (4 + LOCK_WORDS + CLEAN_WORDS) + 4 + LOCK_WORDS
		+ ERROR_WORDS * (LOCK_WORDS + 3) + HEARTBEAT_WORDS + 200;

	logic                       word_clock;
	logic                       rst_n;
	logic                       cmd_req;
	prbs_mode_t                 cmd_mode;
	logic                       cmd_ack;
	logic [WORD_WIDTH-1:0]      tx_word;
	logic                       tx_valid;
	logic [WORD_WIDTH-1:0]      rx_word = '0;
	logic                       rx_valid = 1'b0;
	logic [ERR_COUNT_WIDTH-1:0] error_count;
	logic [3:0]                 leds;

	logic [WORD_WIDTH-1:0]      flip_mask;
	logic [LFSR_WIDTH-1:0]      model_lfsr;
	logic [WORD_WIDTH-1:0]      tx_log[$];
	int                         rx_count;
	int                         cycle_count;
	integer                     seed = 32'hcb1fe079;

	tb_clock u_clock (
		.word_clock (word_clock),
		.rst_n      (rst_n)
	);

	prbs_link_test dut (
		.word_clock  (word_clock),
		.rst_n       (rst_n),
		.cmd_req     (cmd_req),
		.cmd_mode    (cmd_mode),
		.cmd_ack     (cmd_ack),
		.tx_word     (tx_word),
		.tx_valid    (tx_valid),
		.rx_word     (rx_word),
		.rx_valid    (rx_valid),
		.error_count (error_count),
		.leds        (leds)
	);

	// Serial loop with optional bit flips.
	always @(posedge word_clock) begin
		rx_word  <= tx_word ^ flip_mask;
		rx_valid <= tx_valid === 1'b1;
	end

	// A gap in valid starts a new burst.
	always @(posedge word_clock) begin
		if (tx_valid === 1'b1) begin
			tx_log.push_back(tx_word);
		end else begin
			tx_log.delete();
		end
		rx_count = rx_valid ? rx_count + 1 : 0;
	end

	always @(posedge word_clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("The tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$fatal(1, "Timeout");
		end
	end

	// --------------------------------------------------
	// Helpers and reference model
	// --------------------------------------------------
	task automatic check_value(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAILED %s expected %0h actual %0h", test_name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "Mismatch in %s", test_name);
		end
	endtask

	function automatic int model_seed_words(input prbs_mode_t mode);
		int order;
		case (mode)
			MODE_PRBS7:  order = 7;
			MODE_PRBS15: order = 15;
			default:     order = 31;
		endcase
		return (order + 7) / 8;
	endfunction

	// x^7+x^6+1, x^15+x^14+1 and x^31+x^28+1, earliest bit in bit 7.
	task automatic model_next_word(input prbs_mode_t mode, output logic [7:0] word);
		logic fb;
		for (int i = 7; i >= 0; i--) begin
			case (mode)
				MODE_PRBS7:  fb = model_lfsr[6] ^ model_lfsr[5];
				MODE_PRBS15: fb = model_lfsr[14] ^ model_lfsr[13];
				default:     fb = model_lfsr[30] ^ model_lfsr[27];
			endcase
			word[i]    = fb;
			model_lfsr = {model_lfsr[29:0], fb};
		end
	endtask

	function automatic int count_ones(input logic [7:0] value);
		int n;
		n = 0;
		for (int i = 0; i < 8; i++) begin
			n += value[i];
		end
		return n;
	endfunction

	task automatic wait_rx_words(input int count);
		while (rx_count < count) @(negedge word_clock);
	endtask

	// Four-phase command, ack delays counted from the edge that drives req.
	task automatic issue_command(input prbs_mode_t mode);
		int rise_cycles;
		int fall_cycles;
		rise_cycles = 0;
		fall_cycles = 0;
		@(posedge word_clock);
		cmd_req  <= 1'b1;
		cmd_mode <= mode;
		@(negedge word_clock);
		while (cmd_ack !== 1'b1) begin
			@(negedge word_clock);
			rise_cycles++;
		end
		@(posedge word_clock);
		cmd_req <= 1'b0;
		@(negedge word_clock);
		while (cmd_ack !== 1'b0) begin
			@(negedge word_clock);
			fall_cycles++;
		end
		check_value("handshake ack rise", 2, rise_cycles);
		check_value("handshake ack fall", 1, fall_cycles);
	endtask

	// --------------------------------------------------
	// Tests
	// --------------------------------------------------
	task automatic reset_handshake_test();
		check_value("reset cmd_ack", 0, cmd_ack);
		check_value("reset tx_valid", 0, tx_valid);
		check_value("reset leds", 0, leds);
		check_value("reset error_count", 0, error_count);
		issue_command(MODE_PRBS7);
		check_value("handshake run led", 1, leds[1]);
	endtask

	task automatic pattern_test(input prbs_mode_t mode);
		logic [7:0] expected;
		issue_command(mode);
		while (tx_log.size() < PATTERN_WORDS) @(negedge word_clock);
		model_lfsr = '1;
		for (int i = 0; i < PATTERN_WORDS; i++) begin
			model_next_word(mode, expected);
			check_value($sformatf("pattern %s word %0d", mode.name(), i), expected, tx_log[i]);
		end
	endtask

	task automatic clean_loopback_test(input prbs_mode_t mode);
		string name;
		int    lock_at;
		name    = $sformatf("loopback %s", mode.name());
		lock_at = model_seed_words(mode) + LOCK_WORDS;
		issue_command(mode);
		wait_rx_words(lock_at - 1);
		check_value(name, 0, leds[3]);
		@(negedge word_clock);
		check_value(name, 1, leds[3]); // Lock right after the last clean word.
		wait_rx_words(lock_at + CLEAN_WORDS);
		check_value(name, 1, leds[3]);
		check_value(name, 0, leds[2]);
		check_value(name, 0, error_count);
	endtask

	task automatic error_injection_test();
		int         expected_errors;
		int         r;
		logic [7:0] mask;
		expected_errors = 0;
		issue_command(MODE_PRBS31);
		wait_rx_words(model_seed_words(MODE_PRBS31) + LOCK_WORDS);
		check_value("errors initial lock", 1, leds[3]);
		for (int k = 0; k < ERROR_WORDS; k++) begin
			r               = $random(seed);
			mask            = 8'(1 << (r & 7)) | 8'(1 << ((r >> 3) & 7));
			expected_errors += count_ones(mask);
			@(posedge word_clock);
			flip_mask <= mask;
			@(posedge word_clock);
			flip_mask <= '0; // Only one word is hit.
			@(posedge word_clock);
			@(negedge word_clock);
			check_value("errors count", expected_errors, error_count);
			check_value("errors lock drop", 0, leds[3]);
			for (int i = 1; i < LOCK_WORDS; i++) begin
				@(negedge word_clock);
				check_value("errors relock wait", 0, leds[3]);
			end
			@(negedge word_clock);
			check_value("errors relock", 1, leds[3]);
		end
		check_value("errors led", 1, leds[2]);
	endtask

	task automatic restart_off_test();
		issue_command(MODE_PRBS7);
		check_value("restart error_count", 0, error_count);
		check_value("restart error led", 0, leds[2]);
		while (tx_log.size() < HEARTBEAT_WORDS) begin
			check_value("restart heartbeat", (tx_log.size() >> HEARTBEAT_BIT) & 1, leds[0]);
			check_value("restart run led", 1, leds[1]);
			@(negedge word_clock);
		end
		issue_command(MODE_OFF);
		repeat (4) begin
			@(negedge word_clock);
			check_value("off tx_valid", 0, tx_valid);
			check_value("off run led", 0, leds[1]);
		end
	endtask

	initial begin
		cmd_req     = 1'b0;
		cmd_mode    = MODE_OFF;
		flip_mask   = '0;
		model_lfsr  = '1;
		rx_count    = 0;
		cycle_count = 0;
		wait (rst_n === 1'b1);
		@(negedge word_clock);
		reset_handshake_test();
		pattern_test(MODE_PRBS7);
		pattern_test(MODE_PRBS15);
		pattern_test(MODE_PRBS31);
		clean_loopback_test(MODE_PRBS7);
		clean_loopback_test(MODE_PRBS15);
		clean_loopback_test(MODE_PRBS31);
		error_injection_test();
		restart_off_test();
		$display("Simulation passed");
		$finish;
	end

endmodule

//--- sources.f
logic/prbs_pkg.sv
logic/prbs_ctrl_if.sv
logic/prbs_word_gen.sv
logic/prbs_word_check.sv
logic/link_test_ctrl.sv
logic/prbs_link_test.sv
test/tb_clock.sv
test/tb_prbs_link_test.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the PRBS link tester testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_prbs_link_test \
	-f sources.f -o sim_prbs_link_test > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build did not complete"; exit 1; }

./obj_dir/sim_prbs_link_test > sim.log 2>&1
cat sim.log

grep -q "Simulation failed" sim.log && exit 1 || exit 0
